//--- build.f
+incdir+include
src/lim_pkg.sv
src/lim_funct_cell.sv
src/lim_row_select.sv
src/lim_maxmin_ctrl.sv
src/lim_array.sv
src/lim_ram_top.sv
dv/lim_props.sv
dv/lim_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := lim_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
PASS_MSG  := Testbench passed

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; printf '%s\n' "$$out"; printf '%s\n' "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/lim_tb.sv
// directed testbench for the logic-in-memory RAM, compiled from build.f and run by the Makefile
`timescale 1ns/1ns
`default_nettype none

`include "lim_settings.svh"

module lim_tb;
    import lim_pkg::*;

    localparam int TIMEOUT = 100;           // cycles per wait
    localparam logic [`LIM_ADDR_W-1:0] CELL        = `LIM_ADDR_W'(`LIM_FUNCT_ADDR);
    localparam logic [`LIM_ADDR_W-1:0] PLAIN_BASE  = `LIM_ADDR_W'('h100);
    localparam logic [`LIM_ADDR_W-1:0] RANGE_BASE  = `LIM_ADDR_W'('h300);
    localparam logic [`LIM_ADDR_W-1:0] SEARCH_BASE = `LIM_ADDR_W'('h400);
    localparam int RANGE_N  = 5;
    localparam int SEARCH_N = 8;

    logic                    clk_i;
    logic                    rst_ni;
    lim_instr_req_t          instr_req;
    lim_req_t                data_req;
    logic                    gnt_b;
    logic [`LIM_INSTR_W-1:0] rdata_a;
    logic [31:0]             rdata_b;
    logic                    rvalid_b;
    logic [7:0]              model [`LIM_BYTES];    // byte reference of the array

    lim_ram_top dut0 (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .instr_req_i (instr_req),
        .data_req_i  (data_req),
        .gnt_b_i     (gnt_b),
        .rdata_a_o   (rdata_a),
        .rdata_b_o   (rdata_b),
        .rvalid_b_o  (rvalid_b)
    );

    always #4 clk_i = ~clk_i;

    // ====================
    // reporting
    // ====================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    // ====================
    // reference model
    // ====================
    function automatic logic [31:0] model_word(input logic [`LIM_ADDR_W-1:0] addr);
        logic [`LIM_ADDR_W-1:0] a;
        logic [31:0]            w;
        a = {addr[`LIM_ADDR_W-1:2], 2'b00};
        for (int k = 0; k < 4; k++) begin
            w[8*k +: 8] = model[a + `LIM_ADDR_W'(k)];  // little endian
        end
        return w;
    endfunction

    function automatic void model_store(input logic [`LIM_ADDR_W-1:0] addr,
                                        input logic [31:0] data, input logic [3:0] be);
        logic [`LIM_ADDR_W-1:0] a;
        a = {addr[`LIM_ADDR_W-1:2], 2'b00};
        for (int k = 0; k < 4; k++) begin
            if (be[k]) begin
                model[a + `LIM_ADDR_W'(k)] = data[8*k +: 8];
            end
        end
    endfunction

    function automatic logic [31:0] apply_op(input lim_funct_e op, input logic [31:0] a,
                                             input logic [31:0] b);
        case (op)
            FUNCT_AND:  return a & b;
            FUNCT_OR:   return a | b;
            FUNCT_XOR:  return a ^ b;
            FUNCT_NAND: return ~(a & b);
            FUNCT_NOR:  return ~(a | b);
            FUNCT_XNOR: return ~(a ^ b);
            default:    return a;
        endcase
    endfunction

    // ====================
    // bus tasks
    // ====================
    // holds the request until rvalid, lat counts the cycles before it
    task automatic bus_access(input logic we, input logic [`LIM_ADDR_W-1:0] addr,
                              input logic [31:0] wdata, input logic [3:0] be,
                              output logic [31:0] rdata, output int lat);
        bit seen;
        data_req = '{en: 1'b1, we: we, addr: addr, wdata: wdata, be: be};
        gnt_b    = 1'b1;
        seen     = 1'b0;
        lat      = 0;
        while (!seen) begin
            @(negedge clk_i);
            if (rvalid_b) begin
                seen = 1'b1;
            end else begin
                lat++;
                if (lat > TIMEOUT) begin
                    abort_run("timeout: rvalid_b_o never rose for the port B request");
                end
            end
        end
        @(posedge clk_i);
        #1;
        data_req.en = 1'b0;
        gnt_b       = 1'b0;
        rdata       = rdata_b;  // registered at the edge just passed
    endtask

    task automatic store(input logic [`LIM_ADDR_W-1:0] addr, input logic [31:0] wdata,
                         input logic [3:0] be);
        logic [31:0] rd;
        int          lat;
        bus_access(1'b1, addr, wdata, be, rd, lat);
        check_eq("rvalid_b_o latency", 32'(lat), 32'd0);
    endtask

    task automatic load_expect(input logic [`LIM_ADDR_W-1:0] addr, input logic [31:0] mask,
                               input logic [31:0] exp, input int exp_lat);
        logic [31:0] rd;
        int          lat;
        bus_access(1'b0, addr, mask, 4'hF, rd, lat);
        check_eq("rvalid_b_o latency", 32'(lat), 32'(exp_lat));
        check_eq("rdata_b_o", rd, exp);
    endtask

    task automatic fetch_expect(input logic [`LIM_ADDR_W-1:0] addr, input logic [31:0] exp);
        instr_req = '{en: 1'b1, addr: addr};
        @(posedge clk_i);
        #1;
        instr_req.en = 1'b0;
        check_eq("rdata_a_o", rdata_a, exp);
    endtask

    // cell store is a plain write too
    task automatic program_cell(input logic [23:0] asize, input lim_funct_e op);
        store(CELL, {asize, op}, 4'hF);
        model_store(CELL, {asize, op}, 4'hF);
    endtask

    // ====================
    // directed tests
    // ====================
    task automatic test_plain();
        logic [`LIM_ADDR_W-1:0] addr;
        logic [31:0]            data;
        logic [3:0]             be;
        @(negedge clk_i);
        check_eq("rvalid_b_o", {31'd0, rvalid_b}, 32'd0);   // grant low
        @(posedge clk_i);
        #1;
        for (int i = 0; i < 8; i++) begin
            addr = PLAIN_BASE + `LIM_ADDR_W'(4*i);
            data = $urandom;
            store(addr, data, 4'hF);
            model_store(addr, data, 4'hF);
            data = $urandom;
            be   = 4'($urandom);
            store(addr, data, be);
            model_store(addr, data, be);
        end
        for (int i = 0; i < 8; i++) begin
            addr = PLAIN_BASE + `LIM_ADDR_W'(4*i);
            load_expect(addr, 32'd0, model_word(addr), 0);
            fetch_expect(addr, model_word(addr));
        end
    endtask

    task automatic test_bitwise_loads();
        lim_funct_e             op;
        logic [`LIM_ADDR_W-1:0] addr;
        logic [31:0]            mask;
        for (int o = 1; o <= 6; o++) begin
            op = lim_funct_e'(8'(o));
            program_cell(24'd0, op);
            for (int i = 0; i < 4; i++) begin
                addr = PLAIN_BASE + `LIM_ADDR_W'(4*i);
                mask = $urandom;
                load_expect(addr, mask, apply_op(op, model_word(addr), mask), 0);
            end
        end
        program_cell(24'd0, FUNCT_NONE);
        for (int i = 0; i < 4; i++) begin
            addr = PLAIN_BASE + `LIM_ADDR_W'(4*i);
            load_expect(addr, 32'd0, model_word(addr), 0);
        end
    endtask

    task automatic test_bitwise_stores();
        lim_funct_e             op;
        logic [`LIM_ADDR_W-1:0] addr;
        logic [31:0]            data;
        logic [31:0]            exp;
        for (int o = 1; o <= 6; o++) begin
            op   = lim_funct_e'(8'(o));
            addr = PLAIN_BASE + `LIM_ADDR_W'(4*(o-1));
            data = $urandom;
            exp  = apply_op(op, model_word(addr), data);
            program_cell(24'd0, op);
            store(addr, data, 4'(1 << ($urandom % 4)));    // one byte, whole word written
            model_store(addr, exp, 4'hF);
            program_cell(24'd0, FUNCT_NONE);
            load_expect(addr, 32'd0, exp, 0);
        end
    endtask

    task automatic test_range_store();
        logic [`LIM_ADDR_W-1:0] addr;
        logic [31:0]            data;
        for (int i = -1; i <= RANGE_N; i++) begin
            addr = RANGE_BASE + `LIM_ADDR_W'(4*i);
            data = $urandom;
            store(addr, data, 4'hF);
            model_store(addr, data, 4'hF);
        end
        data = $urandom;
        program_cell(24'(RANGE_N), FUNCT_NONE);
        store(RANGE_BASE, data, 4'b0101);
        for (int i = 0; i < RANGE_N; i++) begin
            model_store(RANGE_BASE + `LIM_ADDR_W'(4*i), data, 4'hF);
        end
        program_cell(24'd0, FUNCT_NONE);
        for (int i = -1; i <= RANGE_N; i++) begin    // neighbours included
            addr = RANGE_BASE + `LIM_ADDR_W'(4*i);
            load_expect(addr, 32'd0, model_word(addr), 0);
        end
    endtask

    task automatic test_maxmin();
        logic [`LIM_ADDR_W-1:0] addr;
        logic [31:0]            data;
        logic [31:0]            hi;
        logic [31:0]            lo;
        hi = 32'd0;
        lo = '1;
        for (int i = 0; i < SEARCH_N; i++) begin
            addr = SEARCH_BASE + `LIM_ADDR_W'(4*i);
            data = $urandom;
            store(addr, data, 4'hF);
            model_store(addr, data, 4'hF);
        end
        for (int i = 0; i < SEARCH_N; i++) begin
            data = model_word(SEARCH_BASE + `LIM_ADDR_W'(4*i));
            if (data > hi) begin
                hi = data;
            end
            if (data < lo) begin
                lo = data;
            end
        end
        program_cell(24'(SEARCH_N), FUNCT_MAX);
        load_expect(SEARCH_BASE, 32'd0, hi, `LIM_MAXMIN_ITER - 1);
        program_cell(24'(SEARCH_N), FUNCT_MIN);
        load_expect(SEARCH_BASE, 32'd0, lo, `LIM_MAXMIN_ITER - 1);
        program_cell(24'd0, FUNCT_NONE);
        load_expect(SEARCH_BASE, 32'd0, model_word(SEARCH_BASE), 0);
    endtask

    initial begin
        void'($urandom(32'h79f1_f519));
        clk_i     = 1'b0;
        rst_ni    = 1'b0;
        instr_req = '0;
        data_req  = '0;
        gnt_b     = 1'b0;
        repeat (5) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        test_plain();
        test_bitwise_loads();
        test_bitwise_stores();
        test_range_store();
        test_maxmin();
        if (dut0.u_maxmin_ctrl.u_props.fail_cnt == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            abort_run("assertion failures in the MAX/MIN controller");
        end
    end

endmodule

`default_nettype wire

//--- dv/lim_props.sv
// concurrent checks on the MAX/MIN search controller, bound into every lim_maxmin_ctrl
`timescale 1ns/1ns
`default_nettype none

module lim_props (
    input logic              clk_i,
    input logic              rst_ni,
    input logic              gnt_i,
    input logic              rvalid_i,
    input logic              search_busy_i,
    input logic              search_done_i,
    input logic [31:0]       mask_i,        // mask as seen by the array
    input logic              hold_i,
    input lim_pkg::lim_req_t hold_req_i
);

    int unsigned fail_cnt = 0;              // read by the testbench at the end

    // ====================
    // search control
    // ====================
    // exactly one bit position is compared in every search step
    mask_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        search_busy_i |-> $onehot(mask_i))
        else begin
            fail_cnt++;
            $error("search mask is not one-hot: 0x%08h", mask_i);
        end

    // valid comes from the grant, or from the last search step
    rvalid_source: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rvalid_i |-> (gnt_i || search_done_i))
        else begin
            fail_cnt++;
            $error("rvalid_b_o high without grant or search done");
        end

    held_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $past(hold_i) |-> (hold_req_i == $past(hold_req_i)))
        else begin
            fail_cnt++;
            $error("held request changed during a search");
        end

endmodule

bind lim_maxmin_ctrl lim_props u_props (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .gnt_i         (gnt_i),
    .rvalid_i      (rvalid_o),
    .search_busy_i (search_busy_o),
    .search_done_i (search_done_o),
    .mask_i        (mask_o),
    .hold_i        (hold_q),
    .hold_req_i    (hold_req_q)
);

`default_nettype wire

//--- src/lim_ram_top.sv
// top of the dual-port logic-in-memory RAM, port A instruction fetch and port B data/compute
`timescale 1ns/1ns
`default_nettype none

`include "lim_settings.svh"

module lim_ram_top (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  lim_pkg::lim_instr_req_t instr_req_i,
    input  lim_pkg::lim_req_t       data_req_i,
    input  logic                    gnt_b_i,
    output logic [`LIM_INSTR_W-1:0] rdata_a_o,
    output logic [31:0]             rdata_b_o,
    output logic                    rvalid_b_o
);
    import lim_pkg::*;

    lim_req_t               eff_req;    // held or live port B request
    lim_cfg_t               cfg;
    logic                   funct_hit;
    logic                   range_active;
    logic [`LIM_ADDR_W-1:0] range_end;
    logic [`LIM_BYTES-1:0]  rows;
    logic [`LIM_BYTES-1:0]  enabled_rows;
    logic [`LIM_BYTES-1:0]  wired_or;
    logic [31:0]            mask;
    logic                   search_busy;
    logic                   search_done;

    lim_funct_cell u_funct_cell (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .req_i          (eff_req),
        .cfg_o          (cfg),
        .funct_hit_o    (funct_hit),
        .range_active_o (range_active),
        .range_end_o    (range_end)
    );

    lim_row_select u_row_select (
        .req_i          (eff_req),
        .range_active_i (range_active),
        .range_end_i    (range_end),
        .rows_o         (rows)
    );

    lim_maxmin_ctrl u_maxmin_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .req_i          (data_req_i),
        .gnt_i          (gnt_b_i),
        .opcode_i       (cfg.opcode),
        .funct_hit_i    (funct_hit),
        .rows_i         (rows),
        .wired_or_i     (wired_or),
        .req_o          (eff_req),
        .mask_o         (mask),
        .search_busy_o  (search_busy),
        .search_done_o  (search_done),
        .enabled_rows_o (enabled_rows),
        .rvalid_o       (rvalid_b_o)
    );

    lim_array u_array (
        .clk_i          (clk_i),
        .instr_i        (instr_req_i),
        .req_i          (eff_req),
        .opcode_i       (cfg.opcode),
        .mask_i         (mask),
        .rows_i         (rows),
        .enabled_rows_i (enabled_rows),
        .search_busy_i  (search_busy),
        .search_done_i  (search_done),
        .rdata_a_o      (rdata_a_o),
        .rdata_b_o      (rdata_b_o),
        .wired_or_o     (wired_or)
    );

endmodule

`default_nettype wire

//--- src/lim_array.sv
// byte-addressed storage with in-array AND/OR/XOR compute, write-back and read ports
`timescale 1ns/1ns
`default_nettype none

`include "lim_settings.svh"

module lim_array (
    input  logic                    clk_i,
    input  lim_pkg::lim_instr_req_t instr_i,
    input  lim_pkg::lim_req_t       req_i,
    input  lim_pkg::lim_funct_e     opcode_i,
    input  logic [31:0]             mask_i,
    input  logic [`LIM_BYTES-1:0]   rows_i,
    input  logic [`LIM_BYTES-1:0]   enabled_rows_i,
    input  logic                    search_busy_i,
    input  logic                    search_done_i,
    output logic [`LIM_INSTR_W-1:0] rdata_a_o,
    output logic [31:0]             rdata_b_o,
    output logic [`LIM_BYTES-1:0]   wired_or_o
);
    import lim_pkg::*;

    localparam int WORDS = `LIM_BYTES / 4;

    logic [7:0]             mem [`LIM_BYTES];
    logic [31:0]            word_raw [WORDS];
    logic [31:0]            word_and [WORDS];
    logic [31:0]            word_or  [WORDS];
    logic [31:0]            word_xor [WORDS];
    logic [31:0]            word_res [WORDS];   // result of the active opcode
    logic [WORDS-1:0]       word_sel;
    logic                   bitwise_op;
    logic [31:0]            ld_word;
    logic [31:0]            found_word;
    logic [`LIM_ADDR_W-1:0] addr_a;

    assign bitwise_op = (opcode_i == FUNCT_AND) || (opcode_i == FUNCT_OR)
                     || (opcode_i == FUNCT_XOR) || (opcode_i == FUNCT_NAND)
                     || (opcode_i == FUNCT_NOR) || (opcode_i == FUNCT_XNOR);

    // ====================
    // compute arrays
    // ====================
    always_comb begin
        for (int w = 0; w < WORDS; w++) begin
            word_raw[w] = {mem[4*w+3], mem[4*w+2], mem[4*w+1], mem[4*w]};
            word_and[w] = word_raw[w] & mask_i;
            word_or[w]  = word_raw[w] | mask_i;
            word_xor[w] = word_raw[w] ^ mask_i;
            wired_or_o[4*w +: 4] = {4{|word_and[w]}};  // same value on every byte row
            word_sel[w] = |rows_i[4*w +: 4];
            unique case (opcode_i)
                FUNCT_AND:  word_res[w] = word_and[w];
                FUNCT_OR:   word_res[w] = word_or[w];
                FUNCT_XOR:  word_res[w] = word_xor[w];
                FUNCT_NAND: word_res[w] = ~word_and[w];
                FUNCT_NOR:  word_res[w] = ~word_or[w];
                FUNCT_XNOR: word_res[w] = ~word_xor[w];
                default:    word_res[w] = word_raw[w];
            endcase
        end
    end

    // read muxes, highest selected word wins so a range returns its last word
    always_comb begin
        ld_word    = '0;
        found_word = '0;
        for (int w = 0; w < WORDS; w++) begin
            if (word_sel[w]) begin
                ld_word = word_res[w];
            end
            if (|enabled_rows_i[4*w +: 4]) begin
                found_word = word_raw[w];
            end
        end
    end

    // ====================
    // port B
    // ====================
    always_ff @(posedge clk_i) begin
        if (req_i.en && req_i.we) begin
            for (int w = 0; w < WORDS; w++) begin
                for (int k = 0; k < 4; k++) begin
                    // bitwise store rewrites the whole word
                    if (rows_i[4*w+k] || (bitwise_op && word_sel[w])) begin
                        mem[4*w+k] <= bitwise_op ? word_res[w][8*k +: 8]
                                                 : req_i.wdata[8*k +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i.en && !req_i.we) begin
            if (search_done_i) begin
                rdata_b_o <= found_word;
            end else if (!search_busy_i) begin
                rdata_b_o <= ld_word;
            end
        end
    end

    // port A, instruction fetch
    assign addr_a = {instr_i.addr[`LIM_ADDR_W-1:2], 2'b00};

    always_ff @(posedge clk_i) begin
        if (instr_i.en) begin
            for (int i = 0; i < `LIM_INSTR_W / 8; i++) begin
                rdata_a_o[8*i +: 8] <= mem[addr_a + `LIM_ADDR_W'(i)];
            end
        end
    end

endmodule

`default_nettype wire

//--- src/lim_maxmin_ctrl.sv
// bit-serial MAX/MIN search control: request hold, mask shifter, row narrowing, port B valid
`timescale 1ns/1ns
`default_nettype none

`include "lim_settings.svh"

module lim_maxmin_ctrl (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  lim_pkg::lim_req_t     req_i,
    input  logic                  gnt_i,
    input  lim_pkg::lim_funct_e   opcode_i,
    input  logic                  funct_hit_i,
    input  logic [`LIM_BYTES-1:0] rows_i,
    input  logic [`LIM_BYTES-1:0] wired_or_i,
    output lim_pkg::lim_req_t     req_o,
    output logic [31:0]           mask_o,
    output logic                  search_busy_o,
    output logic                  search_done_o,
    output logic [`LIM_BYTES-1:0] enabled_rows_o,
    output logic                  rvalid_o
);
    import lim_pkg::*;

    localparam logic [31:0] MASK_MSB = 32'd1 << (`LIM_MAXMIN_ITER - 1);

    logic                  hold_q;      // search in progress after the start cycle
    lim_req_t              hold_req_q;
    logic [31:0]           mask_q;
    logic [31:0]           cur_mask;
    logic                  maxmin_op;
    logic                  start;
    logic [`LIM_BYTES-1:0] rows_q;
    logic [`LIM_BYTES-1:0] cur_rows;
    logic [`LIM_BYTES-1:0] cand_rows;

    // ====================
    // effective request
    // ====================
    always_comb begin
        req_o    = req_i;
        req_o.en = req_i.en & gnt_i;    // no access without grant
        if (hold_q) begin
            req_o = hold_req_q;
        end
    end

    assign maxmin_op     = (opcode_i == FUNCT_MAX) || (opcode_i == FUNCT_MIN);
    assign start         = !hold_q && req_o.en && !req_o.we && maxmin_op && !funct_hit_i;
    assign search_busy_o = start || hold_q;

    // msb is checked in the start cycle itself
    assign cur_mask      = start ? MASK_MSB : mask_q;
    assign search_done_o = search_busy_o && cur_mask[0];
    assign mask_o        = search_busy_o ? cur_mask : req_o.wdata;
    assign rvalid_o      = search_busy_o ? search_done_o : gnt_i;

    // ====================
    // row narrowing
    // ====================
    assign cur_rows = start ? rows_i : rows_q;

    always_comb begin
        if (opcode_i == FUNCT_MIN) begin
            cand_rows = ~wired_or_i & cur_rows;     // keep rows with a 0 at this bit
        end else begin
            cand_rows = wired_or_i & cur_rows;
        end
        enabled_rows_o = '0;
        if (search_busy_o) begin
            // all rows agree, nothing to drop
            enabled_rows_o = (|cand_rows) ? cand_rows : cur_rows;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hold_q <= 1'b0;
            mask_q <= '0;
        end else if (search_busy_o) begin
            hold_q <= !search_done_o;
            mask_q <= cur_mask >> 1;    // back to zero after bit 0
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            hold_req_q <= req_o;
        end
        if (search_busy_o) begin
            rows_q <= enabled_rows_o;
        end
    end

endmodule

`default_nettype wire

//--- src/lim_row_select.sv
// byte word-line decoder for single accesses with byte enables and for word ranges
`timescale 1ns/1ns
`default_nettype none

`include "lim_settings.svh"

module lim_row_select (
    input  lim_pkg::lim_req_t      req_i,
    input  logic                   range_active_i,
    input  logic [`LIM_ADDR_W-1:0] range_end_i,
    output logic [`LIM_BYTES-1:0]  rows_o
);

    localparam int WORDS = `LIM_BYTES / 4;

    logic [`LIM_ADDR_W-3:0] start_w;
    logic [`LIM_ADDR_W-3:0] end_w;
    logic [WORDS-1:0]       start_mark;
    logic [WORDS-1:0]       end_mark;
    logic                   in_range;   // running fill state over the words

    assign start_w = req_i.addr[`LIM_ADDR_W-1:2];
    assign end_w   = range_end_i[`LIM_ADDR_W-1:2];

    // one marker at the start word, one at the end word in range mode
    always_comb begin
        start_mark         = '0;
        end_mark           = '0;
        start_mark[start_w] = 1'b1;
        end_mark[end_w]     = range_active_i;
    end

    // ====================
    // word lines
    // ====================
    always_comb begin
        in_range = 1'b0;
        rows_o   = '0;
        for (int w = 0; w < WORDS; w++) begin
            // toggles on at start, off at end, so end is excluded
            in_range = in_range ^ start_mark[w] ^ end_mark[w];
            if (range_active_i) begin
                rows_o[4*w +: 4] = {4{in_range}};   // whole words only
            end else begin
                rows_o[4*w +: 4] = req_i.be & {4{start_mark[w]}};
            end
        end
    end

endmodule

`default_nettype wire

//--- src/lim_funct_cell.sv
// function cell register, programmed by a store to the cell address, plus range decode
`timescale 1ns/1ns
`default_nettype none

`include "lim_settings.svh"

module lim_funct_cell (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  lim_pkg::lim_req_t      req_i,
    output lim_pkg::lim_cfg_t      cfg_o,
    output logic                   funct_hit_o,
    output logic                   range_active_o,
    output logic [`LIM_ADDR_W-1:0] range_end_o
);
    import lim_pkg::*;

    localparam logic [`LIM_ADDR_W-1:0] FUNCT_ADDR = `LIM_ADDR_W'(`LIM_FUNCT_ADDR);

    lim_cfg_t               cfg_q;
    logic [`LIM_ADDR_W-1:0] addr_w;     // word aligned address

    assign addr_w      = {req_i.addr[`LIM_ADDR_W-1:2], 2'b00};
    assign funct_hit_o = req_i.en && (addr_w == FUNCT_ADDR);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cfg_q <= '{asize: 24'd0, opcode: FUNCT_NONE};
        end else if (funct_hit_o && req_i.we) begin
            cfg_q <= lim_cfg_t'(req_i.wdata);
        end
    end

    // programming access itself behaves as a plain access
    always_comb begin
        cfg_o        = cfg_q;
        cfg_o.opcode = funct_hit_o ? FUNCT_NONE : cfg_q.opcode;
    end

    // ====================
    // range decode
    // ====================
    assign range_active_o = req_i.en && (cfg_q.asize > 24'd1) && !funct_hit_o;
    assign range_end_o    = addr_w + {cfg_q.asize[`LIM_ADDR_W-3:0], 2'b00}; // size in bytes

endmodule

`default_nettype wire

//--- src/lim_pkg.sv
// shared opcode enum and request/config structs of the logic-in-memory RAM
`default_nettype none

`include "lim_settings.svh"

package lim_pkg;

    // function cell opcodes, low byte of the cell
    typedef enum logic [7:0] {
        FUNCT_NONE = 8'd0,  // plain access
        FUNCT_AND  = 8'd1,
        FUNCT_OR   = 8'd2,
        FUNCT_XOR  = 8'd3,
        FUNCT_NAND = 8'd4,
        FUNCT_NOR  = 8'd5,
        FUNCT_XNOR = 8'd6,
        FUNCT_MAX  = 8'd7,
        FUNCT_MIN  = 8'd8
    } lim_funct_e;

    // port B request
    typedef struct packed {
        logic                   en;
        logic                   we;     // 1 store, 0 load
        logic [`LIM_ADDR_W-1:0] addr;
        logic [31:0]            wdata;  // also the mask of bitwise ops
        logic [3:0]             be;
    } lim_req_t;

    // function cell content
    typedef struct packed {
        logic [23:0] asize;             // range size in words
        lim_funct_e  opcode;
    } lim_cfg_t;

    // port A request, read only
    typedef struct packed {
        logic                   en;
        logic [`LIM_ADDR_W-1:0] addr;
    } lim_instr_req_t;

endpackage

`default_nettype wire

//--- include/lim_settings.svh
// sizes and special addresses of the logic-in-memory RAM, included by the package and RTL
`ifndef LIM_SETTINGS_SVH
`define LIM_SETTINGS_SVH

// ====================
// memory geometry
// ====================
`define LIM_ADDR_W 12                       // byte address, both ports
`define LIM_BYTES (1 << `LIM_ADDR_W)        // 4 KiB
`define LIM_INSTR_W 32                      // port A read width

// ====================
// logic-in-memory
// ====================
// last word of memory programs the function cell
`define LIM_FUNCT_ADDR (`LIM_BYTES - 4)
`define LIM_MAXMIN_ITER 32                  // one step per data bit

`endif
